// ==== hw/fifo_config.svh ====
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// --------------------
// Buffer geometry
// --------------------

// Bits per stored word
`define FIFO_DATA_WIDTH 16

// Storage array entries, must be a power of two.
// The prefetch stage adds one more word of capacity on top of this.
`define FIFO_DEPTH 32

`endif

// ==== hw/fifo_pkg.sv ====
`default_nettype none

`include "fifo_config.svh"

package fifo_pkg;

    // --------------------
    // Derived sizes
    // --------------------

    // Address bits into the storage array
    localparam int ADDR_WIDTH = $clog2(`FIFO_DEPTH);

    // Array entries plus the prefetch word
    localparam int FIFO_CAPACITY = `FIFO_DEPTH + 1;

    // Wide enough to hold every fill level from 0 up to FIFO_CAPACITY
    localparam int COUNT_WIDTH = $clog2(FIFO_CAPACITY + 1);

    // --------------------
    // Shared types
    // --------------------

    typedef logic [`FIFO_DATA_WIDTH-1:0] data_t;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Address plus wrap bit
    typedef logic [ADDR_WIDTH:0] ptr_t;

    typedef logic [COUNT_WIDTH-1:0] count_t;

endpackage

`default_nettype wire

// ==== hw/fifo_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_config.svh"

module fifo_mem
    import fifo_pkg::*;
(
    // Write port
    input  wire logic  wr_clk,
    input  wire logic  mem_wr_en,
    input  wire addr_t wr_addr,
    input  wire data_t wr_data,

    // Read port
    input  wire logic  rd_clk,
    input  wire logic  mem_rd_en,
    input  wire addr_t rd_addr,
    output data_t      mem_rd_data
);

    // Simple dual-port storage, one clock per port
    data_t storage [`FIFO_DEPTH];

    always_ff @(posedge wr_clk) begin
        if (mem_wr_en) begin
            storage[wr_addr] <= wr_data;
        end
    end

    // Registered read, data is valid one rd_clk cycle after mem_rd_en
    always_ff @(posedge rd_clk) begin
        if (mem_rd_en) begin
            mem_rd_data <= storage[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hw/fifo_ptr_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_ptr_sync
    import fifo_pkg::*;
(
    // Source domain
    input  wire logic src_clk,
    input  wire logic src_srst,
    input  wire ptr_t src_ptr,

    // Destination domain
    input  wire logic dst_clk,
    input  wire logic dst_srst,
    output ptr_t      dst_ptr
);

    localparam int PTR_WIDTH = $bits(ptr_t);

    ptr_t src_gray;
    ptr_t sync_meta;
    ptr_t sync_gray;

    function automatic ptr_t gray_to_bin(input ptr_t gray);
        ptr_t bin;
        bin[PTR_WIDTH-1] = gray[PTR_WIDTH-1];
        for (int i = PTR_WIDTH - 2; i >= 0; i--) begin
            bin[i] = bin[i + 1] ^ gray[i];
        end
        return bin;
    endfunction

    // --------------------
    // Source side
    // --------------------

    // Gray code registered so only one bit can move per source edge
    always_ff @(posedge src_clk) begin
        if (src_srst) begin
            src_gray <= '0;
        end else begin
            src_gray <= src_ptr ^ (src_ptr >> 1);
        end
    end

    // --------------------
    // Destination side
    // --------------------

    // Two-flop synchronizer
    always_ff @(posedge dst_clk) begin
        if (dst_srst) begin
            sync_meta <= '0;
            sync_gray <= '0;
        end else begin
            sync_meta <= src_gray;
            sync_gray <= sync_meta;
        end
    end

    assign dst_ptr = gray_to_bin(sync_gray);

    // A multi-bit step here could be sampled half-way in the other domain
    gray_one_bit_step: assert property (
        @(posedge src_clk) disable iff (src_srst)
        $countones(src_gray ^ $past(src_gray)) <= 1
    );

endmodule

`default_nettype wire

// ==== hw/fifo_fwft_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_fwft_stage
    import fifo_pkg::*;
(
    input  wire logic  rd_clk,
    input  wire logic  rd_srst,

    // Word arriving from the storage array
    input  wire logic  load,
    input  wire data_t mem_rd_data,

    // Consumer side
    input  wire logic  pop,
    output logic       stage_valid,
    output data_t      rd_data
);

    // --------------------
    // Valid flag
    // --------------------

    // Load wins over pop, so a drain and refill in one cycle keeps it set
    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            stage_valid <= 1'b0;
        end else if (load) begin
            stage_valid <= 1'b1;
        end else if (pop) begin
            stage_valid <= 1'b0;
        end
    end

    // --------------------
    // Data register
    // --------------------

    // Oldest word, visible before the read strobe
    always_ff @(posedge rd_clk) begin
        if (load) begin
            rd_data <= mem_rd_data;
        end
    end

    // The controller must never fetch into an occupied stage
    no_load_over_valid: assert property (
        @(posedge rd_clk) disable iff (rd_srst)
        load |-> (!stage_valid || pop)
    );

endmodule

`default_nettype wire

// ==== hw/fifo_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_ctrl
    import fifo_pkg::*;
(
    // Write domain
    input  wire logic wr_clk,
    input  wire logic wr_srst,
    input  wire logic wr,
    input  wire ptr_t rd_ptr_synced,
    output ptr_t      wr_ptr,
    output logic      mem_wr_en,
    output addr_t     wr_addr,
    output logic      full,
    output logic      oflow,
    output count_t    wr_count_int,

    // Read domain
    input  wire logic rd_clk,
    input  wire logic rd_srst,
    input  wire logic rd,
    input  wire ptr_t wr_ptr_synced,
    input  wire logic stage_valid,
    output ptr_t      rd_ptr,
    output logic      mem_rd_en,
    output logic      load,
    output logic      pop,
    output addr_t     rd_addr,
    output logic      rd_ack,
    output logic      uflow,
    output count_t    rd_count_int
);

    ptr_t wr_fill;
    ptr_t rd_fill;
    logic array_empty;

    // --------------------
    // Write side
    // --------------------

    // Same address, opposite wrap bit
    assign full = (wr_ptr == {~rd_ptr_synced[ADDR_WIDTH], rd_ptr_synced[ADDR_WIDTH-1:0]});

    assign mem_wr_en = wr && !full;
    assign wr_addr   = wr_ptr[ADDR_WIDTH-1:0];

    always_ff @(posedge wr_clk) begin
        if (wr_srst) begin
            wr_ptr <= '0;
        end else if (mem_wr_en) begin
            wr_ptr <= wr_ptr + ptr_t'(1);
        end
    end

    // Dropped write flagged one cycle later
    always_ff @(posedge wr_clk) begin
        if (wr_srst) begin
            oflow <= 1'b0;
        end else begin
            oflow <= wr && full;
        end
    end

    // Read pointer lags here, so a word already moved into the prefetch
    // stage stays counted until the pointer crosses over; never reads low
    assign wr_fill      = wr_ptr - rd_ptr_synced;
    assign wr_count_int = count_t'(wr_fill);

    // --------------------
    // Read side
    // --------------------

    assign array_empty = (rd_ptr == wr_ptr_synced);

    assign pop    = rd && stage_valid;
    assign rd_ack = pop;

    // Prefetch when a word waits and the stage is free by the time it lands
    assign mem_rd_en = !array_empty && !load && (!stage_valid || pop);
    assign rd_addr   = rd_ptr[ADDR_WIDTH-1:0];

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            rd_ptr <= '0;
        end else if (mem_rd_en) begin
            rd_ptr <= rd_ptr + ptr_t'(1);
        end
    end

    // Fetch in flight, the array output is valid next cycle
    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            load <= 1'b0;
        end else begin
            load <= mem_rd_en;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            uflow <= 1'b0;
        end else begin
            uflow <= rd && !stage_valid;
        end
    end

    // Array words plus the word in flight or in the stage
    assign rd_fill      = wr_ptr_synced - rd_ptr;
    assign rd_count_int = count_t'(rd_fill) + count_t'(stage_valid) + count_t'(load);

    // --------------------
    // Checks
    // --------------------

    // The write pointer may lead the synced read pointer by one array at most
    wr_within_array: assert property (
        @(posedge wr_clk) disable iff (wr_srst)
        wr_fill <= FIFO_CAPACITY - 1
    );

    // Prefetch never runs past the last word seen from the write side
    rd_within_array: assert property (
        @(posedge rd_clk) disable iff (rd_srst)
        rd_fill <= FIFO_CAPACITY - 1
    );

    wr_count_in_range: assert property (
        @(posedge wr_clk) disable iff (wr_srst)
        wr_count_int <= FIFO_CAPACITY
    );

    rd_count_in_range: assert property (
        @(posedge rd_clk) disable iff (rd_srst)
        rd_count_int <= FIFO_CAPACITY
    );

endmodule

`default_nettype wire

// ==== hw/fifo_async.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_async
    import fifo_pkg::*;
(
    // Write interface
    input  wire logic  wr_clk,
    input  wire logic  wr_srst,
    input  wire logic  wr,
    input  wire data_t wr_data,

    // Read interface
    input  wire logic  rd_clk,
    input  wire logic  rd_srst,
    input  wire logic  rd,
    output logic       rd_ack,
    output data_t      rd_data,

    // Status
    output count_t     wr_count,
    output count_t     rd_count,
    output logic       full,
    output logic       empty,
    output logic       oflow,
    output logic       uflow
);

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    ptr_t   wr_ptr_synced;
    ptr_t   rd_ptr_synced;
    logic   mem_wr_en;
    addr_t  wr_addr;
    logic   mem_rd_en;
    addr_t  rd_addr;
    data_t  mem_rd_data;
    logic   load;
    logic   pop;
    logic   stage_valid;
    count_t wr_count_int;
    count_t rd_count_int;

    // --------------------
    // Control
    // --------------------

    fifo_ctrl fifo_ctrl_i (
        .wr_clk        (wr_clk),
        .wr_srst       (wr_srst),
        .wr            (wr),
        .rd_ptr_synced (rd_ptr_synced),
        .wr_ptr        (wr_ptr),
        .mem_wr_en     (mem_wr_en),
        .wr_addr       (wr_addr),
        .full          (full),
        .oflow         (oflow),
        .wr_count_int  (wr_count_int),
        .rd_clk        (rd_clk),
        .rd_srst       (rd_srst),
        .rd            (rd),
        .wr_ptr_synced (wr_ptr_synced),
        .stage_valid   (stage_valid),
        .rd_ptr        (rd_ptr),
        .mem_rd_en     (mem_rd_en),
        .load          (load),
        .pop           (pop),
        .rd_addr       (rd_addr),
        .rd_ack        (rd_ack),
        .uflow         (uflow),
        .rd_count_int  (rd_count_int)
    );

    // --------------------
    // Datapath
    // --------------------

    fifo_mem fifo_mem_i (
        .wr_clk      (wr_clk),
        .mem_wr_en   (mem_wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_clk      (rd_clk),
        .mem_rd_en   (mem_rd_en),
        .rd_addr     (rd_addr),
        .mem_rd_data (mem_rd_data)
    );

    // Write pointer into the read domain
    fifo_ptr_sync wr_ptr_sync_i (
        .src_clk  (wr_clk),
        .src_srst (wr_srst),
        .src_ptr  (wr_ptr),
        .dst_clk  (rd_clk),
        .dst_srst (rd_srst),
        .dst_ptr  (wr_ptr_synced)
    );

    // Read pointer into the write domain
    fifo_ptr_sync rd_ptr_sync_i (
        .src_clk  (rd_clk),
        .src_srst (rd_srst),
        .src_ptr  (rd_ptr),
        .dst_clk  (wr_clk),
        .dst_srst (wr_srst),
        .dst_ptr  (rd_ptr_synced)
    );

    fifo_fwft_stage fifo_fwft_stage_i (
        .rd_clk      (rd_clk),
        .rd_srst     (rd_srst),
        .load        (load),
        .mem_rd_data (mem_rd_data),
        .pop         (pop),
        .stage_valid (stage_valid),
        .rd_data     (rd_data)
    );

    assign empty = !stage_valid;

    // --------------------
    // Fill counts
    // --------------------

    always_ff @(posedge wr_clk) begin
        if (wr_srst) begin
            wr_count <= '0;
        end else begin
            wr_count <= wr_count_int;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            rd_count <= '0;
        end else begin
            rd_count <= rd_count_int;
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_fifo_async.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fifo_config.svh"

module tb_fifo_async
    import fifo_pkg::*;
;

    localparam logic [31:0] SEED = 32'h5224_a33f;
    // Summed test lengths come to under 2000 rd_clk cycles
    localparam int CYCLE_LIMIT = 4000;

    logic   wr_clk = 1'b0;
    logic   rd_clk = 1'b0;
    logic   wr_srst;
    logic   rd_srst;
    logic   wr;
    data_t  wr_data;
    logic   rd;
    logic   rd_ack;
    data_t  rd_data;
    count_t wr_count;
    count_t rd_count;
    logic   full;
    logic   empty;
    logic   oflow;
    logic   uflow;

    data_t       sb_q[$];
    data_t       exp_head;
    logic        exp_valid = 1'b0;
    logic        first_write_done;
    logic [31:0] wr_rand;
    logic [31:0] rd_rand;
    int          wr_accepted = 0;
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count = 0;

    always #7 wr_clk = ~wr_clk;
    always #5 rd_clk = ~rd_clk;

    fifo_async fifo_async_i (
        .wr_clk   (wr_clk),
        .wr_srst  (wr_srst),
        .wr       (wr),
        .wr_data  (wr_data),
        .rd_clk   (rd_clk),
        .rd_srst  (rd_srst),
        .rd       (rd),
        .rd_ack   (rd_ack),
        .rd_data  (rd_data),
        .wr_count (wr_count),
        .rd_count (rd_count),
        .full     (full),
        .empty    (empty),
        .oflow    (oflow),
        .uflow    (uflow)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // --------------------
    // Scoreboard
    // --------------------

    // Sampled mid-cycle, where strobes and flags have settled
    always @(negedge wr_clk) begin
        if (!wr_srst && wr && !full) begin
            sb_q.push_back(wr_data);
            wr_accepted++;
        end
    end

    // Head before the pop is the word the coming edge must deliver
    always @(negedge rd_clk) begin
        exp_valid <= (sb_q.size() != 0);
        if (sb_q.size() != 0) begin
            exp_head <= sb_q[0];
        end
        if (!rd_srst && rd_ack && sb_q.size() != 0) begin
            void'(sb_q.pop_front());
        end
    end

    // --------------------
    // Checks
    // --------------------

    idle_rd_side: assert property (@(posedge rd_clk) disable iff (rd_srst)
        !first_write_done |-> (empty && !rd_ack && !uflow && rd_count == '0))
    else begin
        $display({"CHECK FAILED after reset: empty=%h rd_ack=%h uflow=%h rd_count=%h,",
                  " expected 1 0 0 0"},
                 $sampled(empty), $sampled(rd_ack), $sampled(uflow), $sampled(rd_count));
        errors++;
    end

    idle_wr_side: assert property (@(posedge wr_clk) disable iff (wr_srst)
        !first_write_done |-> (!full && !oflow && wr_count == '0))
    else begin
        $display("CHECK FAILED after reset: full=%h oflow=%h wr_count=%h, expected 0 0 0",
                 $sampled(full), $sampled(oflow), $sampled(wr_count));
        errors++;
    end

    read_order: assert property (@(posedge rd_clk) disable iff (rd_srst)
        rd_ack |-> (exp_valid && rd_data == exp_head))
    else begin
        if (!$sampled(exp_valid)) begin
            $display("rd_ack came with no written word left to deliver");
        end else begin
            $display("CHECK FAILED rd_data expected %h got %h",
                     $sampled(exp_head), $sampled(rd_data));
        end
        errors++;
    end

    ack_not_empty: assert property (@(posedge rd_clk) disable iff (rd_srst)
        rd_ack |-> !empty)
    else begin
        $display("CHECK FAILED empty expected 0 got 1 while rd_ack is high");
        errors++;
    end

    oflow_on_drop: assert property (@(posedge wr_clk) disable iff (wr_srst)
        (wr && full) |=> oflow)
    else begin
        $display("CHECK FAILED oflow expected 1 got 0 after a write while full");
        errors++;
    end

    oflow_only_on_drop: assert property (@(posedge wr_clk) disable iff (wr_srst)
        oflow |-> $past(wr && full))
    else begin
        $display("CHECK FAILED oflow expected 0 got 1");
        errors++;
    end

    uflow_on_empty_read: assert property (@(posedge rd_clk) disable iff (rd_srst)
        (rd && empty) |=> uflow)
    else begin
        $display("CHECK FAILED uflow expected 1 got 0 after a read while empty");
        errors++;
    end

    uflow_only_on_empty_read: assert property (@(posedge rd_clk) disable iff (rd_srst)
        uflow |-> $past(rd && empty))
    else begin
        $display("CHECK FAILED uflow expected 0 got 1");
        errors++;
    end

    rd_count_bound: assert property (@(posedge rd_clk) disable iff (rd_srst)
        rd_count <= FIFO_CAPACITY)
    else begin
        $display("CHECK FAILED rd_count expected at most %h got %h",
                 FIFO_CAPACITY, $sampled(rd_count));
        errors++;
    end

    wr_count_bound: assert property (@(posedge wr_clk) disable iff (wr_srst)
        wr_count <= FIFO_CAPACITY)
    else begin
        $display("CHECK FAILED wr_count expected at most %h got %h",
                 FIFO_CAPACITY, $sampled(wr_count));
        errors++;
    end

    // --------------------
    // Drivers
    // --------------------

    task automatic drive_write(input logic strobe);
        @(posedge wr_clk);
        #1;
        wr_rand = lcg_step(wr_rand);
        wr = strobe;
        wr_data = data_t'(wr_rand >> 8);
        if (strobe) begin
            first_write_done = 1'b1;
        end
    endtask

    task automatic drive_read(input logic strobe);
        @(posedge rd_clk);
        #1;
        rd = strobe;
    endtask

    // Reads whenever a word is shown, until empty holds for 6 cycles
    task automatic drain_until_idle();
        int idle;
        idle = 0;
        while (idle < 6) begin
            @(posedge rd_clk);
            #1;
            rd = !empty;
            @(negedge rd_clk);
            idle = empty ? idle + 1 : 0;
        end
        drive_read(1'b0);
    endtask

    task automatic report_test(input string name, input int err_mark);
        if (errors == err_mark) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - err_mark);
        end
    endtask

    always @(posedge rd_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d rd_clk cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------
    // Test sequence
    // --------------------

    initial begin
        int err_mark;
        int full_cycles;
        int mark;
        wr = 1'b0;
        wr_data = '0;
        rd = 1'b0;
        wr_srst = 1'b1;
        rd_srst = 1'b1;
        first_write_done = 1'b0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        wr_rand = SEED;
        rd_rand = lcg_step(SEED);
        repeat (2) @(posedge rd_clk);
        #1;
        wr_srst = 1'b0;
        rd_srst = 1'b0;

        err_mark = errors;
        repeat (8) drive_read(1'b0);
        report_test("reset state", err_mark);

        // Write every cycle until full has been seen for 8 cycles
        err_mark = errors;
        mark = wr_accepted;
        full_cycles = 0;
        while (full_cycles < 8) begin
            drive_write(1'b1);
            @(negedge wr_clk);
            if (full) begin
                full_cycles++;
            end
        end
        drive_write(1'b0);
        repeat (2) @(negedge wr_clk);
        assert (wr_accepted - mark == FIFO_CAPACITY)
        else begin
            $display("CHECK FAILED accepted writes expected %h got %h",
                     FIFO_CAPACITY, wr_accepted - mark);
            errors++;
        end
        assert (wr_count >= `FIFO_DEPTH)
        else begin
            $display("CHECK FAILED wr_count expected at least %h got %h", `FIFO_DEPTH, wr_count);
            errors++;
        end
        report_test("fill to capacity", err_mark);

        err_mark = errors;
        mark = wr_accepted;
        repeat (4) drive_write(1'b1);
        drive_write(1'b0);
        @(negedge wr_clk);
        assert (wr_accepted == mark)
        else begin
            $display("CHECK FAILED accepted writes expected %h got %h", mark, wr_accepted);
            errors++;
        end
        report_test("overflow drop", err_mark);

        err_mark = errors;
        drain_until_idle();
        assert (sb_q.size() == 0)
        else begin
            $display("%0d written words never came out", sb_q.size());
            errors++;
        end
        report_test("drain in order", err_mark);

        err_mark = errors;
        drive_read(1'b1);
        repeat (3) drive_read(1'b0);
        report_test("underflow", err_mark);

        // Writes slightly outpace reads so full is reached now and then
        err_mark = errors;
        fork
            repeat (1000) begin
                wr_rand = lcg_step(wr_rand);
                drive_write(wr_rand[31:30] != 2'b00);
            end
            repeat (1500) begin
                rd_rand = lcg_step(rd_rand);
                drive_read(rd_rand[31]);
            end
        join
        drive_write(1'b0);
        drain_until_idle();
        assert (sb_q.size() == 0)
        else begin
            $display("%0d written words never came out", sb_q.size());
            errors++;
        end
        report_test("random traffic", err_mark);

        repeat (4) @(posedge rd_clk);
        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hw
hw/fifo_pkg.sv
hw/fifo_mem.sv
hw/fifo_ptr_sync.sv
hw/fifo_fwft_stage.sv
hw/fifo_ctrl.sv
hw/fifo_async.sv
bench/tb_fifo_async.sv

// ==== Bender.yml ====
package:
  name: fifo_async

sources:
  - include_dirs:
      - hw
    files:
      - hw/fifo_pkg.sv
      - hw/fifo_mem.sv
      - hw/fifo_ptr_sync.sv
      - hw/fifo_fwft_stage.sv
      - hw/fifo_ctrl.sv
      - hw/fifo_async.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_fifo_async.sv
